//--- vlog.f
issue_pkg.sv
dispatch_stage.sv
issue_single.sv
alu_stage.sv
issue_top.sv
issue_asserts.sv
tb_issue_top.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_issue_top
FILELIST  ?= vlog.f
OBJDIR    ?= obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx '=== PASS ==='

clean:
	rm -rf $(OBJDIR)

//--- tb_issue_top.sv
`timescale 1ns/10ps
`default_nettype none

module tb_issue_top;

    import issue_pkg::*;

    localparam int RS_DEPTH     = 8;
    localparam int DISP_W       = 2;
    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 16;
    localparam int N_FIRST      = 160;
    localparam int N_PRE_FLUSH  = 60;
    localparam int N_POST_FLUSH = 80;
    localparam int N_UOPS       = N_FIRST + N_PRE_FLUSH + N_POST_FLUSH;
    localparam int TIMEOUT_NS   = (RESET_CYCLES + N_UOPS * 20) * CLK_PERIOD;

    logic                              clk;
    logic                              rst_n_i;
    logic                              flush_i;
    logic [DISP_W-1:0]                 disp_valid_i;
    uop_t [DISP_W-1:0]                 disp_uop_i;
    logic                              issue_ready_o;
    logic [$clog2(RS_DEPTH+1)-1:0]     free_count_o;
    cdb_t                              cdb_o;

    logic [31:0] rng_state;
    string       test_name;
    logic        saw_full;

    // Model state per tag
    logic        pending [32];
    logic        done [32];
    alu_op_e     m_op [32];
    src_t        m_s1 [32];
    src_t        m_s2 [32];
    logic [31:0] m_res [32];

    issue_top #(
        .RS_DEPTH(RS_DEPTH),
        .DISP_W  (DISP_W)
    ) dut_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .disp_valid_i (disp_valid_i),
        .disp_uop_i   (disp_uop_i),
        .issue_ready_o(issue_ready_o),
        .free_count_o (free_count_o),
        .cdb_o        (cdb_o)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic logic [31:0] alu_ref(alu_op_e op, logic [31:0] a, logic [31:0] b);
        case (op)
            ADD:     return a + b;
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            SLL:     return a << b[4:0];
            SRL:     return a >> b[4:0];
            SLT:     return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: return 32'd0;
        endcase
    endfunction

    // Half the sources wait on an in-flight tag and some reuse a finished result
    function automatic src_t pick_src();
        src_t        s;
        logic [31:0] r;
        logic [4:0]  t;
        logic        found;
        r       = next_rand();
        s.ready = 1'b1;
        s.tag   = r[20:16];
        s.value = next_rand();
        found   = 1'b0;
        for (int k = 0; k < 32; k++) begin
            t = r[12:8] + 5'(k);
            if (!found && !r[1] && pending[t]) begin
                found   = 1'b1;
                s.ready = 1'b0;
                s.tag   = t;
            end else if (!found && r[1:0] == 2'd2 && done[t]) begin
                found   = 1'b1;
                s.tag   = t;
                s.value = m_res[t];
            end
        end
        return s;
    endfunction

    function automatic logic [4:0] alloc_tag();
        logic [4:0] start;
        logic [4:0] t;
        logic [4:0] pick;
        logic       found;
        start = 5'(next_rand());
        pick  = start;
        found = 1'b0;
        for (int k = 0; k < 32; k++) begin
            t = start + 5'(k);
            if (!found && !pending[t]) begin
                found = 1'b1;
                pick  = t;
            end
        end
        return pick;
    endfunction

    function automatic int count_pending();
        int n;
        n = 0;
        for (int t = 0; t < 32; t++) begin
            n = n + int'(pending[t]);
        end
        return n;
    endfunction

    task automatic report_fail(input string line);
        $display("%s", line);
        $display("=== FAIL ===");
        $fatal(1);
    endtask

    task automatic check_cdb();
        logic [4:0]  t;
        logic [31:0] exp;
        if (cdb_o.valid) begin
            t = cdb_o.tag;
            assert (pending[t]) else
                report_fail($sformatf("Tag %0d appeared on the CDB with no micro-op in flight", t));
            assert (m_s1[t].ready && m_s2[t].ready) else
                report_fail($sformatf("Tag %0d completed before its operands were known", t));
            exp = alu_ref(m_op[t], m_s1[t].value, m_s2[t].value);
            assert (cdb_o.value == exp) else
                report_fail($sformatf("Error: %s tag %0d expected %h actual %h",
                                      test_name, t, exp, cdb_o.value));
            pending[t] = 1'b0;
            done[t]    = 1'b1;
            m_res[t]   = exp;
            for (int u = 0; u < 32; u++) begin  // Wake dependents in the model
                if (pending[u] && !m_s1[u].ready && m_s1[u].tag == t) begin
                    m_s1[u].ready = 1'b1;
                    m_s1[u].value = exp;
                end
                if (pending[u] && !m_s2[u].ready && m_s2[u].tag == t) begin
                    m_s2[u].ready = 1'b1;
                    m_s2[u].value = exp;
                end
            end
        end
    endtask

    task automatic drive_bundle(inout int sent, input int n);
        logic [31:0]       r;
        logic [DISP_W-1:0] v;
        uop_t              u;
        r = next_rand();
        v = '0;
        if (!issue_ready_o) begin
            saw_full = 1'b1;
        end
        for (int s = 0; s < DISP_W; s++) begin
            u = '0;
            if (issue_ready_o && r[7:4] != 4'd0 && r[8+2*s +: 2] != 2'd0 && sent < n) begin
                u.op   = alu_op_e'(r[18+3*s +: 3]);
                u.src1 = pick_src();
                u.src2 = pick_src();
                u.dst  = alloc_tag();
                assert (!pending[u.dst]) else report_fail("Tag pool ran out of free tags");
                pending[u.dst] = 1'b1;
                done[u.dst]    = 1'b0;
                m_op[u.dst]    = u.op;
                m_s1[u.dst]    = u.src1;
                m_s2[u.dst]    = u.src2;
                v[s] = 1'b1;
                sent++;
            end
            disp_uop_i[s] = u;
        end
        disp_valid_i = v;
    endtask

    // Stimulus sees the CDB before the model takes it so same-cycle forwarding gets hit
    task automatic run_ops(input int n);
        int sent;
        sent = 0;
        while (sent < n) begin
            @(posedge clk);
            #1;
            drive_bundle(sent, n);
            check_cdb();
        end
    endtask

    task automatic drain_check();
        while (count_pending() != 0) begin
            @(posedge clk);
            #1;
            disp_valid_i = '0;
            check_cdb();
        end
        @(posedge clk);
        #1;
        check_cdb();
        assert (int'(free_count_o) == RS_DEPTH) else
            report_fail($sformatf("Error: %s free_count expected %0d actual %0d",
                                  test_name, RS_DEPTH, free_count_o));
        assert (issue_ready_o) else report_fail("issue_ready_o stayed low after the drain");
    endtask

    task automatic flush_pipe();
        @(posedge clk);
        #1;
        flush_i      = 1'b1;
        disp_valid_i = '0;
        check_cdb();  // Last result before the flush edge is still legal
        @(posedge clk);
        #1;
        flush_i = 1'b0;
        for (int t = 0; t < 32; t++) begin
            pending[t] = 1'b0;
        end
        assert (int'(free_count_o) == RS_DEPTH) else
            report_fail($sformatf("Error: %s free_count expected %0d actual %0d",
                                  test_name, RS_DEPTH, free_count_o));
        check_cdb();
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the pipeline stopped producing results");
        $display("=== FAIL ===");
        $fatal(1);
    end

    initial begin
        clk          = 1'b0;
        rst_n_i      = 1'b0;
        flush_i      = 1'b0;
        disp_valid_i = '0;
        disp_uop_i   = '0;
        rng_state    = 32'h6355_9fa2;
        saw_full     = 1'b0;
        test_name    = "reset";
        for (int t = 0; t < 32; t++) begin
            pending[t] = 1'b0;
            done[t]    = 1'b0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n_i = 1'b1;
        assert (int'(free_count_o) == RS_DEPTH && issue_ready_o && !cdb_o.valid) else
            report_fail("Outputs not idle after reset");

        test_name = "mixed_bursts";
        run_ops(N_FIRST);
        test_name = "drain";
        drain_check();
        test_name = "flush";
        run_ops(N_PRE_FLUSH);
        flush_pipe();
        test_name = "after_flush";
        run_ops(N_POST_FLUSH);
        drain_check();
        assert (saw_full) else report_fail("Bursts never filled the reservation station");

        $display("=== PASS ===");
        $finish;
    end

endmodule

`default_nettype wire

//--- issue_asserts.sv
`timescale 1ns/10ps
`default_nettype none

module issue_asserts #(
    parameter int RS_DEPTH = 8,
    parameter int DISP_W   = 2
) (
    input wire logic                              clk,
    input wire logic                              rst_n_i,
    input wire logic [DISP_W-1:0]                 disp_valid_i,
    input wire logic                              issue_ready_o,
    input wire logic [$clog2(RS_DEPTH+1)-1:0]     free_count_o,
    input wire issue_pkg::cdb_t                   cdb_o
);

    // CDB register clears on the first reset edge
    cdb_idle_in_reset: assert property (@(posedge clk) !rst_n_i |=> !cdb_o.valid)
        else $error("CDB valid during reset");

    free_count_bound: assert property (@(posedge clk) disable iff (!rst_n_i)
        int'(free_count_o) <= RS_DEPTH)
        else $error("Free count above station depth");

    no_dispatch_when_full: assert property (@(posedge clk) disable iff (!rst_n_i)
        (|disp_valid_i) |-> issue_ready_o)
        else $error("Dispatch while issue_ready_o low");

endmodule

bind issue_top issue_asserts #(
    .RS_DEPTH(RS_DEPTH),
    .DISP_W  (DISP_W)
) issue_asserts_i (
    .clk          (clk),
    .rst_n_i      (rst_n_i),
    .disp_valid_i (disp_valid_i),
    .issue_ready_o(issue_ready_o),
    .free_count_o (free_count_o),
    .cdb_o        (cdb_o)
);

`default_nettype wire

//--- issue_top.sv
`timescale 1ns/10ps
`default_nettype none

module issue_top #(
    parameter int RS_DEPTH = 8,
    parameter int DISP_W   = 2
) (
    input  wire logic                              clk,
    input  wire logic                              rst_n_i,
    input  wire logic                              flush_i,
    input  wire logic [DISP_W-1:0]                 disp_valid_i,
    input  wire issue_pkg::uop_t [DISP_W-1:0]      disp_uop_i,
    output wire logic                              issue_ready_o,
    output wire logic [$clog2(RS_DEPTH+1)-1:0]     free_count_o,
    output wire issue_pkg::cdb_t                   cdb_o
);

    import issue_pkg::*;

    logic [DISP_W-1:0] disp_q_valid;
    uop_t [DISP_W-1:0] disp_q_uop;
    issue_t            issue;
    cdb_t              cdb;

    dispatch_stage #(
        .DISP_W(DISP_W)
    ) dispatch_stage_i (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .flush_i     (flush_i),
        .disp_valid_i(disp_valid_i),
        .disp_uop_i  (disp_uop_i),
        .cdb_i       (cdb),
        .disp_valid_o(disp_q_valid),
        .disp_uop_o  (disp_q_uop)
    );

    issue_single #(
        .RS_DEPTH(RS_DEPTH),
        .DISP_W  (DISP_W)
    ) issue_single_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .flush_i      (flush_i),
        .disp_valid_i (disp_q_valid),
        .disp_uop_i   (disp_q_uop),
        .cdb_i        (cdb),
        .issue_o      (issue),
        .free_count_o (free_count_o),
        .issue_ready_o(issue_ready_o)
    );

    alu_stage alu_stage_i (
        .clk    (clk),
        .rst_n_i(rst_n_i),
        .flush_i(flush_i),
        .issue_i(issue),
        .cdb_o  (cdb)
    );

    assign cdb_o = cdb;  // CDB also closes the wakeup loop

endmodule

`default_nettype wire

//--- alu_stage.sv
`timescale 1ns/10ps
`default_nettype none

module alu_stage (
    input  wire logic               clk,
    input  wire logic               rst_n_i,
    input  wire logic               flush_i,
    input  wire issue_pkg::issue_t  issue_i,
    output issue_pkg::cdb_t         cdb_o
);

    import issue_pkg::*;

    logic [DATA_W-1:0] result;
    logic [4:0]        shamt;
    cdb_t              cdb_q;

    assign shamt = issue_i.v2[4:0];

    always_comb begin
        case (issue_i.op)
            ADD:     result = issue_i.v1 + issue_i.v2;
            SUB:     result = issue_i.v1 - issue_i.v2;
            AND:     result = issue_i.v1 & issue_i.v2;
            OR:      result = issue_i.v1 | issue_i.v2;
            XOR:     result = issue_i.v1 ^ issue_i.v2;
            SLL:     result = issue_i.v1 << shamt;
            SRL:     result = issue_i.v1 >> shamt;
            SLT:     result = {{(DATA_W-1){1'b0}}, $signed(issue_i.v1) < $signed(issue_i.v2)};
            default: result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        cdb_q.tag   <= issue_i.dst;
        cdb_q.value <= result;
        if (!rst_n_i || flush_i) begin
            cdb_q.valid <= 1'b0;
        end else begin
            cdb_q.valid <= issue_i.valid;  // One cycle per issued op
        end
    end

    assign cdb_o = cdb_q;

endmodule

`default_nettype wire

//--- issue_single.sv
`timescale 1ns/10ps
`default_nettype none

module issue_single #(
    parameter int RS_DEPTH = 8,
    parameter int DISP_W   = 2
) (
    input  wire logic                              clk,
    input  wire logic                              rst_n_i,
    input  wire logic                              flush_i,
    input  wire logic [DISP_W-1:0]                 disp_valid_i,
    input  wire issue_pkg::uop_t [DISP_W-1:0]      disp_uop_i,
    input  wire issue_pkg::cdb_t                   cdb_i,
    output issue_pkg::issue_t                      issue_o,
    output logic [$clog2(RS_DEPTH+1)-1:0]          free_count_o,
    output logic                                   issue_ready_o
);

    import issue_pkg::*;

    localparam int IDX_W = (RS_DEPTH > 1) ? $clog2(RS_DEPTH) : 1;
    localparam int CNT_W = $clog2(RS_DEPTH+1);
    localparam int AGE_W = 16;  // Wide enough that live stamps never span half the range

    uop_t                 ent_q [RS_DEPTH];
    logic [AGE_W-1:0]     stamp_q [RS_DEPTH];
    logic [RS_DEPTH-1:0]  ent_valid_q;
    logic [AGE_W-1:0]     age_ctr_q;
    issue_t               issue_q;

    logic [RS_DEPTH-1:0]  free_mask;
    logic [RS_DEPTH-1:0]  alloc_mask;
    logic [DISP_W-1:0]    alloc_en;
    logic [IDX_W-1:0]     alloc_idx [DISP_W];

    logic                 sel_found;
    logic [IDX_W-1:0]     sel_idx;
    logic [AGE_W-1:0]     sel_stamp;
    logic [RS_DEPTH-1:0]  sel_mask;

    logic [CNT_W-1:0]     free_cnt;
    logic [CNT_W-1:0]     held_cnt;

    // Modular age compare, a allocated before b
    function automatic logic older(logic [AGE_W-1:0] a, logic [AGE_W-1:0] b);
        logic [AGE_W-1:0] d;
        d = a - b;
        return d[AGE_W-1];
    endfunction

    // Lowest free entry to lowest valid slot
    always_comb begin
        free_mask  = ~ent_valid_q;
        alloc_mask = '0;
        for (int s = 0; s < DISP_W; s++) begin
            alloc_en[s]  = 1'b0;
            alloc_idx[s] = '0;
            for (int i = 0; i < RS_DEPTH; i++) begin
                if (disp_valid_i[s] && !alloc_en[s] && free_mask[i]) begin
                    alloc_en[s]   = 1'b1;
                    alloc_idx[s]  = IDX_W'(i);
                    free_mask[i]  = 1'b0;
                    alloc_mask[i] = 1'b1;
                end
            end
        end
    end

    // Oldest entry with both sources ready
    always_comb begin
        sel_found = 1'b0;
        sel_idx   = '0;
        sel_stamp = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            if (ent_valid_q[i] && ent_q[i].src1.ready && ent_q[i].src2.ready) begin
                if (!sel_found || older(stamp_q[i], sel_stamp)) begin
                    sel_found = 1'b1;
                    sel_idx   = IDX_W'(i);
                    sel_stamp = stamp_q[i];
                end
            end
        end
    end

    assign sel_mask = sel_found ? (RS_DEPTH'(1) << sel_idx) : '0;

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            ent_valid_q <= '0;
        end else begin
            ent_valid_q <= (ent_valid_q & ~sel_mask) | alloc_mask;  // Selected entry leaves now
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            age_ctr_q <= '0;
        end else if (|disp_valid_i) begin
            age_ctr_q <= age_ctr_q + AGE_W'(DISP_W);
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            ent_q[i] <= uop_wake(ent_q[i], cdb_i);  // Tag wakeup
        end
        for (int s = 0; s < DISP_W; s++) begin
            if (alloc_en[s]) begin
                ent_q[alloc_idx[s]]   <= disp_uop_i[s];
                stamp_q[alloc_idx[s]] <= age_ctr_q + AGE_W'(s);
            end
        end
    end

    always_ff @(posedge clk) begin
        issue_q.op  <= ent_q[sel_idx].op;
        issue_q.dst <= ent_q[sel_idx].dst;
        issue_q.v1  <= ent_q[sel_idx].src1.value;
        issue_q.v2  <= ent_q[sel_idx].src2.value;
        if (!rst_n_i || flush_i) begin
            issue_q.valid <= 1'b0;
        end else begin
            issue_q.valid <= sel_found;
        end
    end

    always_comb begin
        free_cnt = '0;
        held_cnt = '0;
        for (int i = 0; i < RS_DEPTH; i++) begin
            free_cnt = free_cnt + CNT_W'(!ent_valid_q[i]);
        end
        for (int s = 0; s < DISP_W; s++) begin
            held_cnt = held_cnt + CNT_W'(disp_valid_i[s]);
        end
    end

    assign issue_o       = issue_q;
    assign free_count_o  = free_cnt;
    assign issue_ready_o = (int'(free_cnt) - int'(held_cnt)) >= DISP_W;  // Room for held plus a full bundle

endmodule

`default_nettype wire

//--- dispatch_stage.sv
`timescale 1ns/10ps
`default_nettype none

module dispatch_stage #(
    parameter int DISP_W = 2
) (
    input  wire logic                              clk,
    input  wire logic                              rst_n_i,
    input  wire logic                              flush_i,
    input  wire logic [DISP_W-1:0]                 disp_valid_i,
    input  wire issue_pkg::uop_t [DISP_W-1:0]      disp_uop_i,
    input  wire issue_pkg::cdb_t                   cdb_i,
    output logic [DISP_W-1:0]                      disp_valid_o,
    output issue_pkg::uop_t [DISP_W-1:0]           disp_uop_o
);

    import issue_pkg::*;

    logic [DISP_W-1:0] valid_q;
    uop_t [DISP_W-1:0] uop_q;

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i) begin
            valid_q <= '0;
        end else begin
            valid_q <= disp_valid_i;  // Bundle held for one cycle only
        end
    end

    // Results broadcast in the dispatch cycle are caught on entry
    always_ff @(posedge clk) begin
        for (int s = 0; s < DISP_W; s++) begin
            uop_q[s] <= uop_wake(disp_uop_i[s], cdb_i);
        end
    end

    // And results broadcast while held reach the RS through the output
    always_comb begin
        for (int s = 0; s < DISP_W; s++) begin
            disp_uop_o[s] = uop_wake(uop_q[s], cdb_i);
        end
    end

    assign disp_valid_o = valid_q;

endmodule

`default_nettype wire

//--- issue_pkg.sv
`default_nettype none

package issue_pkg;

    localparam int DATA_W = 32;
    localparam int TAG_W  = 5;

    typedef enum logic [2:0] {
        ADD = 3'd0,
        SUB = 3'd1,
        AND = 3'd2,
        OR  = 3'd3,
        XOR = 3'd4,
        SLL = 3'd5,  // Shift amount from low 5 bits of operand 2
        SRL = 3'd6,
        SLT = 3'd7   // Signed compare, result 1 or 0
    } alu_op_e;

    typedef struct packed {
        logic              ready;  // Value valid, tag ignored
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] value;
    } src_t;

    typedef struct packed {
        alu_op_e          op;
        logic [TAG_W-1:0] dst;
        src_t             src1;
        src_t             src2;
    } uop_t;

    typedef struct packed {
        logic              valid;
        logic [TAG_W-1:0]  tag;
        logic [DATA_W-1:0] value;
    } cdb_t;

    typedef struct packed {
        logic              valid;
        alu_op_e           op;
        logic [TAG_W-1:0]  dst;
        logic [DATA_W-1:0] v1;
        logic [DATA_W-1:0] v2;
    } issue_t;

    // Capture a broadcast result into a waiting source
    function automatic src_t src_wake(src_t s, cdb_t c);
        src_t r;
        r = s;
        if (c.valid && !s.ready && (s.tag == c.tag)) begin
            r.ready = 1'b1;
            r.value = c.value;
        end
        return r;
    endfunction

    function automatic uop_t uop_wake(uop_t u, cdb_t c);
        uop_t r;
        r      = u;
        r.src1 = src_wake(u.src1, c);
        r.src2 = src_wake(u.src2, c);
        return r;
    endfunction

endpackage

`default_nettype wire
